/* all.f */
+incdir+hdl
hdl/axil_pkg.sv
hdl/axil_chan_reg.sv
hdl/axil_ostd_tracker.sv
hdl/axil_reg_slice.sv
testbench/axil_slave_model.sv
testbench/tb_axil_reg_slice.sv

/* hdl/axil_chan_reg.sv */
/*
 * AXI4-lite channel buffer
 * one-entry valid/ready holding register, one payload type per instance
 * ready toward the source is high only while empty
 */

`timescale 1ns/1ps
`default_nettype none

module axil_chan_reg #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst,

    // source side
    input  wire payload_t in_pl,
    input  wire           in_valid,
    output logic          in_ready,

    // sink side
    output payload_t      out_pl,
    output logic          out_valid,
    input  wire           out_ready
);

    logic     full_q;
    payload_t pl_q;
    logic     in_fire;
    logic     out_fire;

    // ==============================
    // handshakes
    // ==============================
    assign in_ready = !full_q;
    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    // full flag
    // in and out transfers never coincide, ready is low while full
    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (in_fire) begin
            full_q <= 1'b1;
        end else if (out_fire) begin
            full_q <= 1'b0;
        end
    end

    // payload, captured on input transfer only
    always_ff @(posedge clk) begin
        if (in_fire) begin
            pl_q <= in_pl;
        end
    end

    assign out_pl    = pl_q;
    assign out_valid = full_q;

    // ==============================
    // checks
    // ==============================
    // stalled output holds its payload
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_pl)
    );

    // nothing gets in while the entry still waits for the sink
    a_no_fill_when_full: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> !in_fire
    );

endmodule

`default_nettype wire

/* hdl/axil_consts.svh */
/*
 * AXI4-lite register slice constants
 * bus widths and the outstanding-transaction limit
 */

`ifndef AXIL_CONSTS_SVH
`define AXIL_CONSTS_SVH

// ==============================
// bus widths
// ==============================
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32
// one strobe per data byte
`define AXIL_STRB_WIDTH 4

// ==============================
// outstanding tracking
// ==============================
// per direction, upstream side
`define AXIL_OSTD_MAX   16
// wide enough to hold the limit itself
`define AXIL_OSTD_WIDTH 5

`endif

/* hdl/axil_ostd_tracker.sv */
/*
 * AXI4-lite outstanding transaction tracker
 * up/down counts of upstream writes and reads accepted but not yet answered
 */

`timescale 1ns/1ps
`default_nettype none

`include "axil_consts.svh"

module axil_ostd_tracker (
    input  wire                 clk,
    input  wire                 rst,

    // upstream handshake pulses
    input  wire                 aw_fire,
    input  wire                 b_fire,
    input  wire                 ar_fire,
    input  wire                 r_fire,

    // status
    output axil_pkg::ostd_cnt_t wr_ostd,
    output axil_pkg::ostd_cnt_t rd_ostd
);

    axil_pkg::ostd_cnt_t wr_cnt_q;
    axil_pkg::ostd_cnt_t rd_cnt_q;

    // next count from request and response pulses
    // both at once leaves it unchanged
    function automatic axil_pkg::ostd_cnt_t step_count(
        input axil_pkg::ostd_cnt_t cnt,
        input logic                req,
        input logic                rsp
    );
        axil_pkg::ostd_cnt_t nxt;
        nxt = cnt;
        if (req && !rsp) begin
            nxt = cnt + axil_pkg::ostd_cnt_t'(1);
        end else if (rsp && !req) begin
            nxt = cnt - axil_pkg::ostd_cnt_t'(1);
        end
        return nxt;
    endfunction

    // ==============================
    // counters
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt_q <= '0;
            rd_cnt_q <= '0;
        end else begin
            wr_cnt_q <= step_count(wr_cnt_q, aw_fire, b_fire);
            rd_cnt_q <= step_count(rd_cnt_q, ar_fire, r_fire);
        end
    end

    assign wr_ostd = wr_cnt_q;
    assign rd_ostd = rd_cnt_q;

    // ==============================
    // checks
    // ==============================
    // a response always answers an earlier request through the slice
    a_wr_no_underflow: assert property (
        @(posedge clk) disable iff (rst) b_fire |-> wr_cnt_q != '0
    );
    a_rd_no_underflow: assert property (
        @(posedge clk) disable iff (rst) r_fire |-> rd_cnt_q != '0
    );

    // upstream master keeps within the limit
    a_wr_no_overflow: assert property (
        @(posedge clk) disable iff (rst) int'(wr_cnt_q) <= `AXIL_OSTD_MAX
    );
    a_rd_no_overflow: assert property (
        @(posedge clk) disable iff (rst) int'(rd_cnt_q) <= `AXIL_OSTD_MAX
    );

endmodule

`default_nettype wire

/* hdl/axil_pkg.sv */
/*
 * AXI4-lite register slice types
 * bus field types and the payload struct of each channel
 */

`default_nettype none

`include "axil_consts.svh"

package axil_pkg;

    // ==============================
    // bus fields
    // ==============================
    typedef logic [`AXIL_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXIL_STRB_WIDTH-1:0] strb_t;
    typedef logic [2:0]                  prot_t;
    typedef logic [1:0]                  resp_t;

    // encodings as AXI4-lite defines them
    typedef enum resp_t {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // ==============================
    // channel payloads
    // ==============================
    // AW and AR carry the same fields
    typedef struct packed {
        addr_t addr;
        prot_t prot;
    } aw_pl_t;

    typedef struct packed {
        addr_t addr;
        prot_t prot;
    } ar_pl_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_pl_t;

    typedef struct packed {
        resp_e resp;
    } b_pl_t;

    typedef struct packed {
        data_t data;
        resp_e resp;
    } r_pl_t;

    // outstanding transaction count
    typedef logic [`AXIL_OSTD_WIDTH-1:0] ostd_cnt_t;

endpackage

`default_nettype wire

/* hdl/axil_reg_slice.sv */
/*
 * AXI4-lite register slice
 * one-entry buffer on each of AW, W, B, AR and R between upstream and
 * downstream, plus upstream outstanding counts for quiescence checks
 */

`timescale 1ns/1ps
`default_nettype none

module axil_reg_slice (
    input  wire                   clk,
    input  wire                   rst,

    // ==============================
    // upstream, slave port
    // ==============================
    input  wire axil_pkg::addr_t  s_axil_awaddr,
    input  wire axil_pkg::prot_t  s_axil_awprot,
    input  wire                   s_axil_awvalid,
    output logic                  s_axil_awready,
    input  wire axil_pkg::data_t  s_axil_wdata,
    input  wire axil_pkg::strb_t  s_axil_wstrb,
    input  wire                   s_axil_wvalid,
    output logic                  s_axil_wready,
    output axil_pkg::resp_t       s_axil_bresp,
    output logic                  s_axil_bvalid,
    input  wire                   s_axil_bready,
    input  wire axil_pkg::addr_t  s_axil_araddr,
    input  wire axil_pkg::prot_t  s_axil_arprot,
    input  wire                   s_axil_arvalid,
    output logic                  s_axil_arready,
    output axil_pkg::data_t       s_axil_rdata,
    output axil_pkg::resp_t       s_axil_rresp,
    output logic                  s_axil_rvalid,
    input  wire                   s_axil_rready,

    // ==============================
    // downstream, master port
    // ==============================
    output axil_pkg::addr_t       m_axil_awaddr,
    output axil_pkg::prot_t       m_axil_awprot,
    output logic                  m_axil_awvalid,
    input  wire                   m_axil_awready,
    output axil_pkg::data_t       m_axil_wdata,
    output axil_pkg::strb_t       m_axil_wstrb,
    output logic                  m_axil_wvalid,
    input  wire                   m_axil_wready,
    input  wire axil_pkg::resp_t  m_axil_bresp,
    input  wire                   m_axil_bvalid,
    output logic                  m_axil_bready,
    output axil_pkg::addr_t       m_axil_araddr,
    output axil_pkg::prot_t       m_axil_arprot,
    output logic                  m_axil_arvalid,
    input  wire                   m_axil_arready,
    input  wire axil_pkg::data_t  m_axil_rdata,
    input  wire axil_pkg::resp_t  m_axil_rresp,
    input  wire                   m_axil_rvalid,
    output logic                  m_axil_rready,

    // upstream outstanding counts
    output axil_pkg::ostd_cnt_t   wr_ostd,
    output axil_pkg::ostd_cnt_t   rd_ostd
);

    // payloads before and after each buffer
    axil_pkg::aw_pl_t aw_in;
    axil_pkg::aw_pl_t aw_out;
    axil_pkg::w_pl_t  w_in;
    axil_pkg::w_pl_t  w_out;
    axil_pkg::ar_pl_t ar_in;
    axil_pkg::ar_pl_t ar_out;
    axil_pkg::b_pl_t  b_in;
    axil_pkg::b_pl_t  b_out;
    axil_pkg::r_pl_t  r_in;
    axil_pkg::r_pl_t  r_out;

    // upstream handshake pulses for the tracker
    logic aw_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;

    // ==============================
    // packing
    // ==============================
    // requests from upstream
    assign aw_in.addr = s_axil_awaddr;
    assign aw_in.prot = s_axil_awprot;
    assign w_in.data  = s_axil_wdata;
    assign w_in.strb  = s_axil_wstrb;
    assign ar_in.addr = s_axil_araddr;
    assign ar_in.prot = s_axil_arprot;

    // responses from downstream, raw code carried as the enum
    assign b_in.resp  = axil_pkg::resp_e'(m_axil_bresp);
    assign r_in.data  = m_axil_rdata;
    assign r_in.resp  = axil_pkg::resp_e'(m_axil_rresp);

    // ==============================
    // request side
    // ==============================
    axil_chan_reg #(.payload_t(axil_pkg::aw_pl_t)) u_aw_reg (
        .clk       (clk),
        .rst       (rst),
        .in_pl     (aw_in),
        .in_valid  (s_axil_awvalid),
        .in_ready  (s_axil_awready),
        .out_pl    (aw_out),
        .out_valid (m_axil_awvalid),
        .out_ready (m_axil_awready)
    );

    axil_chan_reg #(.payload_t(axil_pkg::w_pl_t)) u_w_reg (
        .clk       (clk),
        .rst       (rst),
        .in_pl     (w_in),
        .in_valid  (s_axil_wvalid),
        .in_ready  (s_axil_wready),
        .out_pl    (w_out),
        .out_valid (m_axil_wvalid),
        .out_ready (m_axil_wready)
    );

    axil_chan_reg #(.payload_t(axil_pkg::ar_pl_t)) u_ar_reg (
        .clk       (clk),
        .rst       (rst),
        .in_pl     (ar_in),
        .in_valid  (s_axil_arvalid),
        .in_ready  (s_axil_arready),
        .out_pl    (ar_out),
        .out_valid (m_axil_arvalid),
        .out_ready (m_axil_arready)
    );

    // ==============================
    // outstanding tracking
    // ==============================
    // counted on the upstream side only
    assign aw_fire = s_axil_awvalid && s_axil_awready;
    assign b_fire  = s_axil_bvalid && s_axil_bready;
    assign ar_fire = s_axil_arvalid && s_axil_arready;
    assign r_fire  = s_axil_rvalid && s_axil_rready;

    axil_ostd_tracker u_ostd (
        .clk     (clk),
        .rst     (rst),
        .aw_fire (aw_fire),
        .b_fire  (b_fire),
        .ar_fire (ar_fire),
        .r_fire  (r_fire),
        .wr_ostd (wr_ostd),
        .rd_ostd (rd_ostd)
    );

    // ==============================
    // response side
    // ==============================
    axil_chan_reg #(.payload_t(axil_pkg::b_pl_t)) u_b_reg (
        .clk       (clk),
        .rst       (rst),
        .in_pl     (b_in),
        .in_valid  (m_axil_bvalid),
        .in_ready  (m_axil_bready),
        .out_pl    (b_out),
        .out_valid (s_axil_bvalid),
        .out_ready (s_axil_bready)
    );

    axil_chan_reg #(.payload_t(axil_pkg::r_pl_t)) u_r_reg (
        .clk       (clk),
        .rst       (rst),
        .in_pl     (r_in),
        .in_valid  (m_axil_rvalid),
        .in_ready  (m_axil_rready),
        .out_pl    (r_out),
        .out_valid (s_axil_rvalid),
        .out_ready (s_axil_rready)
    );

    // ==============================
    // unpacking
    // ==============================
    // buffered requests toward downstream
    assign m_axil_awaddr = aw_out.addr;
    assign m_axil_awprot = aw_out.prot;
    assign m_axil_wdata  = w_out.data;
    assign m_axil_wstrb  = w_out.strb;
    assign m_axil_araddr = ar_out.addr;
    assign m_axil_arprot = ar_out.prot;

    // buffered responses toward upstream
    assign s_axil_bresp  = b_out.resp;
    assign s_axil_rdata  = r_out.data;
    assign s_axil_rresp  = r_out.resp;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the register slice testbench with Verilator, run it, scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_axil_reg_slice --Mdir obj_dir -f all.f \
    && ./obj_dir/Vtb_axil_reg_slice 2>&1 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

/* testbench/axil_slave_model.sv */
/*
 * AXI4-lite downstream memory model
 * 16 words behind the slice, byte merge under wstrb, SLVERR from 64 upward
 * request readies drop at random to stall the slice
 */

`timescale 1ns/1ps
`default_nettype none

module axil_slave_model (
    input  wire                  clk,
    input  wire                  rst,
    input  wire axil_pkg::addr_t awaddr,
    input  wire                  awvalid,
    output logic                 awready,
    input  wire axil_pkg::data_t wdata,
    input  wire axil_pkg::strb_t wstrb,
    input  wire                  wvalid,
    output logic                 wready,
    output axil_pkg::resp_t      bresp,
    output logic                 bvalid,
    input  wire                  bready,
    input  wire axil_pkg::addr_t araddr,
    input  wire                  arvalid,
    output logic                 arready,
    output axil_pkg::data_t      rdata,
    output axil_pkg::resp_t      rresp,
    output logic                 rvalid,
    input  wire                  rready
);

    localparam int MEM_WORDS  = 16;
    localparam int ADDR_LIMIT = 64;

    axil_pkg::data_t mem [MEM_WORDS];
    integer          seed = 32'h012eeaa7;

    // write halves, held until both are in
    logic            aw_full;
    logic            w_full;
    axil_pkg::addr_t aw_addr_q;
    axil_pkg::data_t w_data_q;
    axil_pkg::strb_t w_strb_q;

    // responses waiting for the slice
    logic            b_full;
    axil_pkg::resp_t b_resp_q;
    logic            r_full;
    axil_pkg::data_t r_data_q;
    axil_pkg::resp_t r_resp_q;

    // ==============================
    // state, on the rising edge
    // ==============================
    always @(posedge clk) begin
        if (rst) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            b_full  <= 1'b0;
            r_full  <= 1'b0;
            // fill depends on the whole word index
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= 32'h5a00_0000 | (i * 32'h0001_0203);
            end
        end else begin
            if (awvalid && awready) begin
                aw_full   <= 1'b1;
                aw_addr_q <= awaddr;
            end
            if (wvalid && wready) begin
                w_full   <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
            end
            // both halves in and the B slot free
            if (aw_full && w_full && !b_full) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                b_full  <= 1'b1;
                if (aw_addr_q < ADDR_LIMIT) begin
                    b_resp_q <= axil_pkg::RESP_OKAY;
                    for (int k = 0; k < 4; k++) begin
                        if (w_strb_q[k]) begin
                            mem[aw_addr_q[5:2]][8*k +: 8] <= w_data_q[8*k +: 8];
                        end
                    end
                end else begin
                    b_resp_q <= axil_pkg::RESP_SLVERR;
                end
            end
            if (bvalid && bready) begin
                b_full <= 1'b0;
            end
            // one read in flight, answered from the memory
            if (arvalid && arready) begin
                r_full <= 1'b1;
                if (araddr < ADDR_LIMIT) begin
                    r_data_q <= mem[araddr[5:2]];
                    r_resp_q <= axil_pkg::RESP_OKAY;
                end else begin
                    r_data_q <= '0;
                    r_resp_q <= axil_pkg::RESP_SLVERR;
                end
            end
            if (rvalid && rready) begin
                r_full <= 1'b0;
            end
        end
    end

    // ==============================
    // outputs, on the falling edge
    // ==============================
    always @(negedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            // about one stall in four per request channel
            awready <= !aw_full && (($random(seed) & 3) != 0);
            wready  <= !w_full && (($random(seed) & 3) != 0);
            arready <= !r_full && (($random(seed) & 3) != 0);
            bvalid  <= b_full;
            bresp   <= b_resp_q;
            rvalid  <= r_full;
            rdata   <= r_data_q;
            rresp   <= r_resp_q;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_axil_reg_slice.sv */
/*
 * testbench for the AXI4-lite register slice
 * directed writes and reads through the slice into a memory model
 * checks data, responses, prot, handshake flags and outstanding counts
 */

`timescale 1ns/1ps
`default_nettype none

module tb_axil_reg_slice;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int ADDR_LIMIT     = 64;

    logic                clk;
    logic                rst;

    // upstream side
    axil_pkg::addr_t     s_axil_awaddr;
    axil_pkg::prot_t     s_axil_awprot;
    logic                s_axil_awvalid;
    logic                s_axil_awready;
    axil_pkg::data_t     s_axil_wdata;
    axil_pkg::strb_t     s_axil_wstrb;
    logic                s_axil_wvalid;
    logic                s_axil_wready;
    axil_pkg::resp_t     s_axil_bresp;
    logic                s_axil_bvalid;
    logic                s_axil_bready;
    axil_pkg::addr_t     s_axil_araddr;
    axil_pkg::prot_t     s_axil_arprot;
    logic                s_axil_arvalid;
    logic                s_axil_arready;
    axil_pkg::data_t     s_axil_rdata;
    axil_pkg::resp_t     s_axil_rresp;
    logic                s_axil_rvalid;
    logic                s_axil_rready;

    // downstream side
    axil_pkg::addr_t     m_axil_awaddr;
    axil_pkg::prot_t     m_axil_awprot;
    logic                m_axil_awvalid;
    logic                m_axil_awready;
    axil_pkg::data_t     m_axil_wdata;
    axil_pkg::strb_t     m_axil_wstrb;
    logic                m_axil_wvalid;
    logic                m_axil_wready;
    axil_pkg::resp_t     m_axil_bresp;
    logic                m_axil_bvalid;
    logic                m_axil_bready;
    axil_pkg::addr_t     m_axil_araddr;
    axil_pkg::prot_t     m_axil_arprot;
    logic                m_axil_arvalid;
    logic                m_axil_arready;
    axil_pkg::data_t     m_axil_rdata;
    axil_pkg::resp_t     m_axil_rresp;
    logic                m_axil_rvalid;
    logic                m_axil_rready;

    // status
    axil_pkg::ostd_cnt_t wr_ostd;
    axil_pkg::ostd_cnt_t rd_ostd;

    // expected memory and pending counts, kept from our own handshakes
    axil_pkg::data_t     ref_mem [16];
    int                  wr_pend;
    int                  rd_pend;
    // prot of the request now in flight
    axil_pkg::prot_t     exp_awprot;
    axil_pkg::prot_t     exp_arprot;
    int                  data_errs;
    int                  resp_errs;
    int                  ostd_errs;
    int                  prot_errs;
    int                  flag_errs;
    int                  other_errs;

    axil_reg_slice u_axil_reg_slice (.*);

    axil_slave_model u_slave (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (m_axil_awaddr),
        .awvalid (m_axil_awvalid),
        .awready (m_axil_awready),
        .wdata   (m_axil_wdata),
        .wstrb   (m_axil_wstrb),
        .wvalid  (m_axil_wvalid),
        .wready  (m_axil_wready),
        .bresp   (m_axil_bresp),
        .bvalid  (m_axil_bvalid),
        .bready  (m_axil_bready),
        .araddr  (m_axil_araddr),
        .arvalid (m_axil_arvalid),
        .arready (m_axil_arready),
        .rdata   (m_axil_rdata),
        .rresp   (m_axil_rresp),
        .rvalid  (m_axil_rvalid),
        .rready  (m_axil_rready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_data(input string name, input axil_pkg::data_t exp,
                              input axil_pkg::data_t act);
        if (act !== exp) begin
            data_errs++;
            $display("error at time %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input axil_pkg::resp_t exp,
                              input axil_pkg::resp_t act);
        if (act !== exp) begin
            resp_errs++;
            $display("error at time %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_ostd(input string name, input axil_pkg::ostd_cnt_t exp,
                              input axil_pkg::ostd_cnt_t act);
        if (act !== exp) begin
            ostd_errs++;
            $display("error at time %0t: %s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_prot(input string name, input axil_pkg::prot_t exp,
                              input axil_pkg::prot_t act);
        if (act !== exp) begin
            prot_errs++;
            $display("error at time %0t: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("error at time %0t: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    // requests leave the slice with the prot they came in with
    always @(negedge clk) begin
        if (!rst && m_axil_awvalid) begin
            check_prot("m_axil_awprot", exp_awprot, m_axil_awprot);
        end
        if (!rst && m_axil_arvalid) begin
            check_prot("m_axil_arprot", exp_arprot, m_axil_arprot);
        end
    end

    // ==============================
    // expected values
    // ==============================
    // model contents right after reset
    function automatic axil_pkg::data_t fill_word(input int idx);
        return 32'h5a00_0000 | (idx * 32'h0001_0203);
    endfunction

    // new byte where its strobe is set, old byte elsewhere
    function automatic axil_pkg::data_t merge_bytes(input axil_pkg::data_t old_w,
                                                    input axil_pkg::data_t new_w,
                                                    input axil_pkg::strb_t strb);
        axil_pkg::data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (new_w & mask) | (old_w & ~mask);
    endfunction

    // ==============================
    // bus transactions
    // ==============================
    // B is left waiting for hold cycles once it shows up
    task automatic write_word(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                              input axil_pkg::strb_t strb, input int hold);
        int              n;
        logic            aw_go;
        logic            w_go;
        axil_pkg::resp_t exp_resp;
        axil_pkg::resp_t first_resp;
        exp_resp = (addr < ADDR_LIMIT) ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        exp_awprot     = axil_pkg::prot_t'(addr[4:2]);
        s_axil_awaddr  = addr;
        s_axil_awprot  = exp_awprot;
        s_axil_awvalid = 1'b1;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_wvalid  = 1'b1;
        n = 0;
        // ready seen now means a transfer at the next rising edge
        while ((s_axil_awvalid || s_axil_wvalid) && n < TIMEOUT_CYCLES) begin
            aw_go = s_axil_awvalid && s_axil_awready;
            w_go  = s_axil_wvalid && s_axil_wready;
            @(negedge clk);
            if (aw_go) begin
                s_axil_awvalid = 1'b0;
                wr_pend++;
                check_ostd("wr_ostd", axil_pkg::ostd_cnt_t'(wr_pend), wr_ostd);
            end
            if (w_go) begin
                s_axil_wvalid = 1'b0;
            end
            n++;
        end
        if (s_axil_awvalid || s_axil_wvalid) begin
            other_errs++;
            $display("timeout at time %0t: write to %h was not accepted", $time, addr);
            s_axil_awvalid = 1'b0;
            s_axil_wvalid  = 1'b0;
        end
        n = 0;
        while (!s_axil_bvalid && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_bvalid) begin
            other_errs++;
            $display("timeout at time %0t: no write response for %h", $time, addr);
        end else begin
            first_resp = s_axil_bresp;
            // stalled response holds still and stays counted
            repeat (hold) begin
                @(negedge clk);
                check_flag("s_axil_bvalid", 1'b1, s_axil_bvalid);
                check_resp("s_axil_bresp", first_resp, s_axil_bresp);
                check_ostd("wr_ostd", axil_pkg::ostd_cnt_t'(wr_pend), wr_ostd);
            end
            check_resp("s_axil_bresp", exp_resp, s_axil_bresp);
            s_axil_bready = 1'b1;
            @(negedge clk);
            s_axil_bready = 1'b0;
            wr_pend--;
            check_ostd("wr_ostd", axil_pkg::ostd_cnt_t'(wr_pend), wr_ostd);
            if (addr < ADDR_LIMIT) begin
                ref_mem[addr[5:2]] = merge_bytes(ref_mem[addr[5:2]], data, strb);
            end
        end
    endtask

    task automatic read_word(input axil_pkg::addr_t addr);
        int   n;
        logic ar_go;
        exp_arprot     = ~axil_pkg::prot_t'(addr[4:2]);
        s_axil_araddr  = addr;
        s_axil_arprot  = exp_arprot;
        s_axil_arvalid = 1'b1;
        n = 0;
        while (s_axil_arvalid && n < TIMEOUT_CYCLES) begin
            ar_go = s_axil_arready;
            @(negedge clk);
            if (ar_go) begin
                s_axil_arvalid = 1'b0;
                rd_pend++;
                check_ostd("rd_ostd", axil_pkg::ostd_cnt_t'(rd_pend), rd_ostd);
            end
            n++;
        end
        if (s_axil_arvalid) begin
            other_errs++;
            $display("timeout at time %0t: read of %h was not accepted", $time, addr);
            s_axil_arvalid = 1'b0;
        end
        n = 0;
        while (!s_axil_rvalid && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_rvalid) begin
            other_errs++;
            $display("timeout at time %0t: no read data for %h", $time, addr);
        end else begin
            if (addr < ADDR_LIMIT) begin
                check_resp("s_axil_rresp", axil_pkg::RESP_OKAY, s_axil_rresp);
                check_data("s_axil_rdata", ref_mem[addr[5:2]], s_axil_rdata);
            end else begin
                check_resp("s_axil_rresp", axil_pkg::RESP_SLVERR, s_axil_rresp);
            end
            s_axil_rready = 1'b1;
            @(negedge clk);
            s_axil_rready = 1'b0;
            rd_pend--;
            check_ostd("rd_ostd", axil_pkg::ostd_cnt_t'(rd_pend), rd_ostd);
        end
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic reset_values();
        check_flag("s_axil_bvalid", 1'b0, s_axil_bvalid);
        check_flag("s_axil_rvalid", 1'b0, s_axil_rvalid);
        check_flag("m_axil_awvalid", 1'b0, m_axil_awvalid);
        check_flag("m_axil_wvalid", 1'b0, m_axil_wvalid);
        check_flag("m_axil_arvalid", 1'b0, m_axil_arvalid);
        check_flag("s_axil_awready", 1'b1, s_axil_awready);
        check_flag("s_axil_wready", 1'b1, s_axil_wready);
        check_flag("s_axil_arready", 1'b1, s_axil_arready);
        check_flag("m_axil_bready", 1'b1, m_axil_bready);
        check_flag("m_axil_rready", 1'b1, m_axil_rready);
        check_ostd("wr_ostd", '0, wr_ostd);
        check_ostd("rd_ostd", '0, rd_ostd);
    endtask

    task automatic write_read_back();
        write_word(32'h10, 32'hdead_beef, 4'hf, 0);
        read_word(32'h10);
    endtask

    task automatic strobe_merge();
        write_word(32'h14, 32'h1122_3344, 4'hf, 0);
        write_word(32'h14, 32'haabb_ccdd, 4'b0101, 0);
        read_word(32'h14);
    endtask

    // 0x48 would alias word 2 if the model ignored the range
    task automatic out_of_range();
        write_word(32'h48, 32'hffff_ffff, 4'hf, 0);
        read_word(32'h48);
        read_word(32'h08);
    endtask

    // B held off for 20 cycles before it is taken
    task automatic back_pressure();
        write_word(32'h20, 32'h0bad_cafe, 4'hf, 20);
    endtask

    // every tenth access lands out of range
    task automatic load_counts();
        axil_pkg::addr_t addr;
        for (int i = 0; i < 30; i++) begin
            addr = axil_pkg::addr_t'(((i * 7) % 16) * 4 + ((i % 10 == 9) ? 64 : 0));
            if (i % 3 == 2) begin
                read_word(addr);
            end else begin
                write_word(addr, (i * 32'h0101_0101) ^ 32'h5555_0000,
                           axil_pkg::strb_t'(i) | 4'b0001, 0);
            end
        end
    endtask

    initial begin
        rst            = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awprot  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arprot  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        exp_awprot = '0;
        exp_arprot = '0;
        wr_pend    = 0;
        rd_pend    = 0;
        data_errs  = 0;
        resp_errs  = 0;
        ostd_errs  = 0;
        prot_errs  = 0;
        flag_errs  = 0;
        other_errs = 0;
        for (int i = 0; i < 16; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        reset_values();
        write_read_back();
        strobe_merge();
        out_of_range();
        back_pressure();
        load_counts();

        $display("errors: data %0d, resp %0d, ostd %0d, prot %0d, flag %0d, other %0d",
                 data_errs, resp_errs, ostd_errs, prot_errs, flag_errs, other_errs);
        if (data_errs + resp_errs + ostd_errs + prot_errs + flag_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
